// File: wiscIsaPkg.sv
`default_nettype none

package wiscIsaPkg;

   localparam int wordW    = 16;                  // data and address width
   localparam int regAddrW = 3;                   // eight gprs

   localparam logic [regAddrW-1:0] r7 = 3'd7;     // link reg for jal/jalr

   // top five instruction bits
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opSiic  = 5'b00010,                         // no exceptions, runs as nop
      opRti   = 5'b00011,                         // same
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opJalr  = 5'b00111,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opBltz  = 5'b01110,
      opBgez  = 5'b01111,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opRoli  = 5'b10100,
      opSlli  = 5'b10101,
      opRori  = 5'b10110,
      opSrli  = 5'b10111,
      opLbi   = 5'b11000,
      opBtr   = 5'b11001,
      opShift = 5'b11010,                         // rol/sll/ror/srl by func
      opArith = 5'b11011,                         // add/sub/xor/andn by func
      opSeq   = 5'b11100,
      opSlt   = 5'b11101,
      opSle   = 5'b11110,
      opSco   = 5'b11111
   } opcodeT;

   // instr[1:0], meaning depends on the group
   typedef enum logic [1:0] {
      fnAddRol  = 2'b00,
      fnSubSll  = 2'b01,
      fnXorRor  = 2'b10,
      fnAndnSrl = 2'b11
   } aluFuncT;

endpackage

`default_nettype wire

// File: wiscCtrlPkg.sv
`default_nettype none

package wiscCtrlPkg;

   typedef enum logic [1:0] {wbPcPlus, wbMem, wbAlu, wbImm8} wbSelT;   // writeback source
   typedef enum logic [1:0] {bReg, bImm, bZero, bImm8} bSrcT;          // bImm is imm5
   typedef enum logic [1:0] {destRs, destRt, destRd, destR7} destSelT; // 10:8, 7:5, 4:2, r7

   typedef enum logic [2:0] {
      aluAdd, aluXor, aluAndn, aluRol, aluSll, aluRor, aluSrl, aluSlbi
   } aluOpT;

   // brchSig coding, bit2 sign, bit1 zero, bit0 carry
   localparam logic [2:0] brNever    = 3'b000;
   localparam logic [2:0] brCarry    = 3'b001;
   localparam logic [2:0] brZero     = 3'b010;
   localparam logic [2:0] brNotSign  = 3'b011;
   localparam logic [2:0] brSign     = 3'b100;
   localparam logic [2:0] brNotZero  = 3'b101;
   localparam logic [2:0] brSignZero = 3'b110;
   localparam logic [2:0] brAlways   = 3'b111;

   typedef struct packed {
      aluOpT      aluOp;
      logic       invA;      // subtract is ~A + B + 1
      logic       invB;      // gives the n of andn
      logic       cIn;
      bSrcT       bSrc;
      logic       zeroExt;   // imm5/imm8 zero extended
      logic       regWrite;
      destSelT    destSel;
      wbSelT      wbSel;
      logic       memWrite;
      logic [2:0] brchSig;
      logic       setOp;     // aluOut becomes the condition bit
      logic       pcFromAlu; // jr, jalr
      logic       jumpImm11; // j, jal use the 11 bit displacement
      logic       bitRev;    // btr
      logic       halt;
      logic       illegal;
   } ctrlT;

   typedef struct packed {
      logic zero;
      logic sign;    // signed A < B
      logic carry;
   } aluFlagsT;

   localparam ctrlT ctrlNop = '{
      aluOp: aluAdd, invA: 1'b0, invB: 1'b0, cIn: 1'b0, bSrc: bReg, zeroExt: 1'b0,
      regWrite: 1'b0, destSel: destRs, wbSel: wbAlu, memWrite: 1'b0, brchSig: brNever,
      setOp: 1'b0, pcFromAlu: 1'b0, jumpImm11: 1'b0, bitRev: 1'b0, halt: 1'b0, illegal: 1'b0
   };

   // same rule serves branches and set ops
   function automatic logic condMet(logic [2:0] sel, aluFlagsT f);
      case (sel)
         brCarry:    return f.carry;
         brZero:     return f.zero;
         brNotSign:  return !f.sign;            // bgez
         brSign:     return f.sign;
         brNotZero:  return !f.zero;
         brSignZero: return f.sign | f.zero;    // sle
         brAlways:   return 1'b1;
         default:    return 1'b0;
      endcase
   endfunction

endpackage

`default_nettype wire

// File: controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit (
   input  wire logic [wiscIsaPkg::wordW-1:0] instr,
   output wiscCtrlPkg::ctrlT                 ctrl
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   opcodeT  op;
   aluFuncT fn;

   assign op = opcodeT'(instr[15:11]);
   assign fn = aluFuncT'(instr[1:0]);

   // rotate/shift select, shared by imm and reg forms
   function automatic aluOpT shiftOp(logic [1:0] sel);
      case (sel)
         2'b00:   return aluRol;
         2'b01:   return aluSll;
         2'b10:   return aluRor;
         default: return aluSrl;
      endcase
   endfunction

   always_comb begin
      ctrl = ctrlNop;                                   // everything inactive
      case (op)
         opHalt: ctrl.halt = 1'b1;
         opNop, opSiic, opRti: ;                        // nothing
         opJ: begin
            ctrl.brchSig   = brAlways;
            ctrl.jumpImm11 = 1'b1;                      // pc+2+disp
         end
         opJal: begin
            ctrl.brchSig   = brAlways;
            ctrl.jumpImm11 = 1'b1;
            ctrl.regWrite  = 1'b1;
            ctrl.destSel   = destR7;
            ctrl.wbSel     = wbPcPlus;                  // link
         end
         opJr, opJalr: begin
            ctrl.bSrc      = bImm8;                     // Rs + sext imm8
            ctrl.pcFromAlu = 1'b1;
            ctrl.regWrite  = (op == opJalr);
            ctrl.destSel   = destR7;
            ctrl.wbSel     = wbPcPlus;
         end
         opAddi, opSubi, opXori, opAndni: begin
            ctrl.bSrc     = bImm;
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = destRt;                     // bits 7:5
            ctrl.zeroExt  = op[1];                      // xori/andni zero extend
            ctrl.invA     = (op == opSubi);             // imm - Rs
            ctrl.cIn      = (op == opSubi);
            ctrl.invB     = (op == opAndni);
            ctrl.aluOp    = (op == opXori) ? aluXor :
                            (op == opAndni) ? aluAndn : aluAdd;
         end
         opBeqz, opBnez, opBltz, opBgez: begin
            ctrl.bSrc = bZero;                          // flags of Rs - 0
            case (op)
               opBeqz:  ctrl.brchSig = brZero;
               opBnez:  ctrl.brchSig = brNotZero;
               opBltz:  ctrl.brchSig = brSign;
               default: ctrl.brchSig = brNotSign;
            endcase
         end
         opSt, opLd, opStu: begin
            ctrl.bSrc     = bImm;                       // Rs + sext imm5
            ctrl.memWrite = (op != opLd);
            ctrl.regWrite = (op != opSt);
            ctrl.destSel  = (op == opStu) ? destRs : destRt; // stu bumps base
            ctrl.wbSel    = (op == opLd) ? wbMem : wbAlu;
         end
         opSlbi: begin
            ctrl.aluOp    = aluSlbi;
            ctrl.bSrc     = bImm8;
            ctrl.zeroExt  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = destRs;
         end
         opLbi: begin
            ctrl.regWrite = 1'b1;                       // sext imm8 straight in
            ctrl.destSel  = destRs;
            ctrl.wbSel    = wbImm8;
         end
         opRoli, opSlli, opRori, opSrli: begin
            ctrl.aluOp    = shiftOp(instr[12:11]);
            ctrl.bSrc     = bImm;
            ctrl.zeroExt  = 1'b1;
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = destRt;
         end
         opBtr: begin
            if (fn != fnAddRol) begin
               ctrl.illegal = 1'b1;                     // func bits reserved
            end else begin
               ctrl.bitRev   = 1'b1;
               ctrl.regWrite = 1'b1;
               ctrl.destSel  = destRd;
            end
         end
         opShift: begin
            ctrl.aluOp    = shiftOp(fn);
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = destRd;
         end
         opArith: begin
            ctrl.invA     = (fn == fnSubSll);           // Rt - Rs
            ctrl.cIn      = (fn == fnSubSll);
            ctrl.invB     = (fn == fnAndnSrl);
            ctrl.aluOp    = (fn == fnXorRor) ? aluXor :
                            (fn == fnAndnSrl) ? aluAndn : aluAdd;
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = destRd;
         end
         opSeq, opSlt, opSle, opSco: begin
            ctrl.setOp    = 1'b1;                       // add path feeds sco carry
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = destRd;
            case (op)
               opSeq:   ctrl.brchSig = brZero;
               opSlt:   ctrl.brchSig = brSign;
               opSle:   ctrl.brchSig = brSignZero;
               default: ctrl.brchSig = brCarry;
            endcase
         end
         default: ctrl.illegal = 1'b1;                  // unknown fetch
      endcase
   end

endmodule

`default_nettype wire

// File: regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
   input  wire logic                            clk,
   input  wire logic                            arstN,
   input  wire logic [wiscIsaPkg::regAddrW-1:0] rdAddrA,
   input  wire logic [wiscIsaPkg::regAddrW-1:0] rdAddrB,
   input  wire logic [wiscIsaPkg::regAddrW-1:0] wrAddr,
   input  wire logic [wiscIsaPkg::wordW-1:0]    wrData,
   input  wire logic                            wrEn,
   output logic      [wiscIsaPkg::wordW-1:0]    rdDataA,
   output logic      [wiscIsaPkg::wordW-1:0]    rdDataB
);
   import wiscIsaPkg::*;

   logic [wordW-1:0] regs [2**regAddrW];

   // no bypass, same-cycle read sees old value
   assign rdDataA = regs[rdAddrA];
   assign rdDataB = regs[rdAddrB];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < 2**regAddrW; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

endmodule

`default_nettype wire

// File: alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu (
   input  wire logic [wiscIsaPkg::wordW-1:0] inA,
   input  wire logic [wiscIsaPkg::wordW-1:0] inB,
   input  wire wiscCtrlPkg::ctrlT            ctrl,
   output logic      [wiscIsaPkg::wordW-1:0] aluOut,
   output wiscCtrlPkg::aluFlagsT             flags
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   logic [wordW-1:0]   opA;
   logic [wordW-1:0]   opB;
   logic [wordW:0]     sum;        // msb is carry out
   logic [wordW-1:0]   diff;
   logic               overflow;
   logic [3:0]         shAmt;
   logic [2*wordW-1:0] rolWide;
   logic [2*wordW-1:0] rorWide;
   logic [wordW-1:0]   revA;
   logic [wordW-1:0]   opResult;

   assign opA   = ctrl.invA ? ~inA : inA;
   assign opB   = ctrl.invB ? ~inB : inB;
   assign shAmt = inB[3:0];                                   // low 4 bits only

   assign sum     = {1'b0, opA} + {1'b0, opB} + {{wordW{1'b0}}, ctrl.cIn};
   assign rolWide = {opA, opA} << shAmt;                      // wrap via doubled word
   assign rorWide = {opA, opA} >> shAmt;

   // compare path, always A - B on raw operands
   assign diff     = inA - inB;
   assign overflow = (inA[wordW-1] != inB[wordW-1]) && (diff[wordW-1] != inA[wordW-1]);

   assign flags.zero  = (diff == '0);
   assign flags.sign  = diff[wordW-1] ^ overflow;             // true signed less-than
   assign flags.carry = sum[wordW];

   always_comb begin
      for (int i = 0; i < wordW; i++) begin
         revA[i] = inA[wordW-1-i];                            // btr
      end
   end

   always_comb begin
      case (ctrl.aluOp)
         aluAdd:  opResult = sum[wordW-1:0];
         aluXor:  opResult = opA ^ opB;
         aluAndn: opResult = opA & opB;                       // invB already applied
         aluRol:  opResult = rolWide[2*wordW-1:wordW];
         aluSll:  opResult = opA << shAmt;
         aluRor:  opResult = rorWide[wordW-1:0];
         aluSrl:  opResult = opA >> shAmt;
         default: opResult = {opA[wordW-9:0], 8'h00} | opB;   // slbi
      endcase
   end

   always_comb begin
      if (ctrl.setOp) begin
         aluOut = {{(wordW-1){1'b0}}, condMet(ctrl.brchSig, flags)};
      end else if (ctrl.bitRev) begin
         aluOut = revA;
      end else begin
         aluOut = opResult;
      end
   end

endmodule

`default_nettype wire

// File: pcUnit.sv
`timescale 1ns/100ps
`default_nettype none

module pcUnit (
   input  wire logic                         clk,
   input  wire logic                         arstN,
   input  wire wiscCtrlPkg::ctrlT            ctrl,
   input  wire wiscCtrlPkg::aluFlagsT        flags,
   input  wire logic [wiscIsaPkg::wordW-1:0] brOffset,    // sext imm8
   input  wire logic [wiscIsaPkg::wordW-1:0] jumpOffset,  // sext imm11
   input  wire logic [wiscIsaPkg::wordW-1:0] aluOut,
   output logic      [wiscIsaPkg::wordW-1:0] pc,
   output logic      [wiscIsaPkg::wordW-1:0] pcPlus2,
   output logic                              halted,
   output logic                              err
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   logic             taken;
   logic [wordW-1:0] target;
   logic [wordW-1:0] nextPc;

   assign pcPlus2 = pc + wordW'(2);

   // set ops share brchSig but never redirect
   assign taken  = !ctrl.setOp && condMet(ctrl.brchSig, flags);
   assign target = pcPlus2 + (ctrl.jumpImm11 ? jumpOffset : brOffset);

   always_comb begin
      if (ctrl.pcFromAlu) begin
         nextPc = aluOut;                     // jr, jalr
      end else if (taken) begin
         nextPc = target;
      end else begin
         nextPc = pcPlus2;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc     <= '0;
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (!halted) begin
         if (ctrl.halt || ctrl.illegal) begin
            halted <= 1'b1;                   // pc stays on the stopping instr
            err    <= ctrl.illegal;
         end else begin
            pc <= nextPc;
         end
      end
   end

endmodule

`default_nettype wire

// File: wiscCore.sv
`timescale 1ns/100ps
`default_nettype none

module wiscCore (
   input  wire logic                         clk,
   input  wire logic                         arstN,
   output logic      [wiscIsaPkg::wordW-1:0] instrAddr,
   input  wire logic [wiscIsaPkg::wordW-1:0] instr,
   output logic      [wiscIsaPkg::wordW-1:0] memAddr,
   output logic      [wiscIsaPkg::wordW-1:0] memWData,
   output logic                              memWrite,
   input  wire logic [wiscIsaPkg::wordW-1:0] memRData,
   output logic                              halted,
   output logic                              err
);
   import wiscIsaPkg::*;
   import wiscCtrlPkg::*;

   ctrlT                ctrl;
   aluFlagsT            flags;
   logic [wordW-1:0]    pc;
   logic [wordW-1:0]    pcPlus2;
   logic [wordW-1:0]    rdDataA;
   logic [wordW-1:0]    rdDataB;
   logic [wordW-1:0]    aluOut;
   logic [wordW-1:0]    inB;
   logic [wordW-1:0]    wrData;
   logic [regAddrW-1:0] wrAddr;
   logic [wordW-1:0]    imm5Ext;
   logic [wordW-1:0]    imm8Ext;
   logic [wordW-1:0]    brOffset;
   logic [wordW-1:0]    jumpOffset;

   assign imm5Ext    = ctrl.zeroExt ? {{(wordW-5){1'b0}}, instr[4:0]}
                                    : {{(wordW-5){instr[4]}}, instr[4:0]};
   assign imm8Ext    = ctrl.zeroExt ? {{(wordW-8){1'b0}}, instr[7:0]}
                                    : {{(wordW-8){instr[7]}}, instr[7:0]};
   assign brOffset   = {{(wordW-8){instr[7]}}, instr[7:0]};    // branches always signed
   assign jumpOffset = {{(wordW-11){instr[10]}}, instr[10:0]};

   always_comb begin
      case (ctrl.bSrc)
         bReg:    inB = rdDataB;
         bImm:    inB = imm5Ext;
         bZero:   inB = '0;
         default: inB = imm8Ext;
      endcase
      case (ctrl.wbSel)
         wbPcPlus: wrData = pcPlus2;          // jal/jalr link
         wbMem:    wrData = memRData;
         wbAlu:    wrData = aluOut;
         default:  wrData = imm8Ext;          // lbi
      endcase
      case (ctrl.destSel)
         destRs:  wrAddr = instr[10:8];
         destRt:  wrAddr = instr[7:5];
         destRd:  wrAddr = instr[4:2];
         default: wrAddr = r7;
      endcase
   end

   assign instrAddr = pc;
   assign memAddr   = aluOut;                 // Rs + imm5
   assign memWData  = rdDataB;                // Rd of st/stu, pre-write value
   assign memWrite  = ctrl.memWrite && !halted;

   controlUnit uCtrl (
      .instr (instr),
      .ctrl  (ctrl)
   );

   regFile uRegs (
      .clk     (clk),
      .arstN   (arstN),
      .rdAddrA (instr[10:8]),
      .rdAddrB (instr[7:5]),
      .wrAddr  (wrAddr),
      .wrData  (wrData),
      .wrEn    (ctrl.regWrite && !halted),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB)
   );

   alu uAlu (
      .inA    (rdDataA),
      .inB    (inB),
      .ctrl   (ctrl),
      .aluOut (aluOut),
      .flags  (flags)
   );

   pcUnit uPc (
      .clk        (clk),
      .arstN      (arstN),
      .ctrl       (ctrl),
      .flags      (flags),
      .brOffset   (brOffset),
      .jumpOffset (jumpOffset),
      .aluOut     (aluOut),
      .pc         (pc),
      .pcPlus2    (pcPlus2),
      .halted     (halted),
      .err        (err)
   );

endmodule

`default_nettype wire

// File: wiscCore_assert.sv
`timescale 1ns/100ps
`default_nettype none

module wiscCore_assert (
   input wire logic                         clk,
   input wire logic                         arstN,
   input wire logic [wiscIsaPkg::wordW-1:0] instrAddr,
   input wire logic                         memWrite,
   input wire logic                         halted,
   input wire logic                         err
);

   noStoreWhenHalted: assert property (@(posedge clk) disable iff (!arstN)
      halted |-> !memWrite)
      else $error("memWrite high while halted");

   errMeansHalted: assert property (@(posedge clk) disable iff (!arstN)
      err |-> halted)
      else $error("err set without halted");

   pcFrozen: assert property (@(posedge clk) disable iff (!arstN)
      halted |=> $stable(instrAddr))           // pc holds after halt
      else $error("instrAddr moved while halted");

   pcEven: assert property (@(posedge clk) disable iff (!arstN)
      !instrAddr[0])
      else $error("odd instrAddr");

endmodule

bind wiscCore wiscCore_assert uAssert (.*);

`default_nettype wire

// File: wiscCore_tb.sv
`timescale 1ns/100ps
`default_nettype none

module wiscCore_tb;
   import wiscIsaPkg::*;

   localparam int blockW  = 64;                 // words per block in the data file
   localparam int instrW  = 32;                 // instruction slots per block
   localparam int pairOfs = 32;                 // expected addr/data pairs start here

   logic             clk;
   logic             arstN;
   logic [wordW-1:0] instrAddr;
   logic [wordW-1:0] instr;
   logic [wordW-1:0] memAddr;
   logic [wordW-1:0] memWData;
   logic             memWrite;
   logic [wordW-1:0] memRData;
   logic             halted;
   logic             err;

   logic [wordW-1:0] testData [1024];
   logic [wordW-1:0] rom [64];
   logic [wordW-1:0] ram [256];
   int               blockBase;
   int               expCount;
   int               storeCnt;
   int               checkCount;
   int               errCount;
   int               numBlocks;
   longint           limitNs;

   assign instr    = rom[instrAddr[6:1]];       // same-cycle fetch
   assign memRData = ram[memAddr[8:1]];

   wiscCore DUT (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      if (arstN && memWrite) begin
         ram[memAddr[8:1]] <= memWData;
      end
   end

   // each store compared mid-cycle against the next expected pair
   always @(negedge clk) begin : storeCheck
      int pairAt;
      if (arstN && memWrite) begin
         pairAt = blockBase + pairOfs + 2 * storeCnt;
         checkCount++;
         assert (storeCnt < expCount) else begin
            $display("unexpected extra store to %h at %0t", memAddr, $time);
            errCount++;
         end
         if (storeCnt < expCount) begin
            checkCount++;
            assert (memAddr == testData[pairAt] && memWData == testData[pairAt+1]) else begin
               $display("[FAIL] %0t store %0d got %h <- %h, expected %h <- %h", $time,
                        storeCnt, memAddr, memWData, testData[pairAt], testData[pairAt+1]);
               errCount++;
            end
         end
         storeCnt++;
      end
   end

   task automatic loadMemories();
      for (int i = 0; i < 64; i++) begin
         if (i < instrW && !$isunknown(testData[blockBase+i])) begin
            rom[i] = testData[blockBase+i];
         end else begin
            rom[i] = 16'h0000;                      // halt
         end
      end
      for (int i = 0; i < 256; i++) begin
         ram[i] = {8'(i) ^ 8'h5a, ~8'(i)};
      end
   endtask

   task automatic runBlock(input int b);
      @(posedge clk);
      arstN <= 1'b0;
      blockBase = b * blockW;
      expCount  = int'(testData[blockBase+63]);
      storeCnt  = 0;
      loadMemories();
      repeat (10) @(posedge clk);
      arstN <= 1'b1;
      for (int c = 0; c < 200 && !halted; c++) begin
         @(negedge clk);                            // halted settled mid-cycle
      end
      checkCount += 3;
      assert (halted == testData[blockBase+61][0]) else begin
         $display("[FAIL] %0t block %0d halted %b, expected %b", $time, b, halted,
                  testData[blockBase+61][0]);
         errCount++;
      end
      assert (err == testData[blockBase+62][0]) else begin
         $display("[FAIL] %0t block %0d err %b, expected %b", $time, b, err,
                  testData[blockBase+62][0]);
         errCount++;
      end
      assert (storeCnt == expCount) else begin
         $display("[FAIL] %0t block %0d saw %0d stores, expected %0d", $time, b,
                  storeCnt, expCount);
         errCount++;
      end
   endtask

   initial begin
      arstN      = 1'b0;
      checkCount = 0;
      errCount   = 0;
      blockBase  = 0;
      expCount   = 0;
      storeCnt   = 0;
      limitNs    = 0;
      loadMemories();
      $readmemh("wiscCore_testdata.txt", testData);
      numBlocks = 0;
      // a present block always expects a halt
      while (numBlocks < 16 && testData[numBlocks*blockW+61] == 16'h0001) begin
         numBlocks++;
      end
      limitNs = longint'(numBlocks + 1) * 210 * 100;   // 200 cycles plus reset per block
      for (int b = 0; b < numBlocks; b++) begin
         runBlock(b);
      end
      $display("blocks %0d, checks %0d, errors %0d", numBlocks, checkCount, errCount);
      if (errCount == 0 && numBlocks > 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   initial begin : watchdog
      wait (limitNs != 0);
      #(limitNs);
      $display("timeout, the DUT did not reach halt in time");
      $display("Something failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: wiscCore_testdata.txt
// blocks of 64 words: 0..31 instruction words, 32..59 expected store addr/data pairs,
// 61 expected halted, 62 expected err, 63 expected store count
// block 0: immediate and R-format arithmetic, ld, stu
@000 C112 4145 8040 4963 8062 517F 8064 5962 8066 D950 8088 D951 808A
     D952 808C DA33 808E 88A2 C620 86A0 9E42 86C2 0000
@020 0000 0017 0002 FFF1 0004 000D 0006 0010 0008 0029 000A 0005 000C 0005
     000E 0005 0020 FFF1 0022 0017 0024 0022
@03D 0001 0000 000B
// block 1: rotates and shifts, lbi, slbi, btr
@040 C181 9123 A144 8040 A944 8042 B144 8044 B944 8046 C308 D170 8088 D171
     808A D172 808C D173 808E C910 C610 8680 8622 0000
@060 0000 1238 0002 1230 0004 3812 0006 0812 0008 2381 000A 2300 000C 2381
     000E 0081 0010 C481 0012 8123
@07D 0001 0000 000A
// block 2: set ops and guarded stores behind branches
@080 C105 C2FD E14C 8060 E12C 8062 EA2C 8064 F14C 8066 F94C 8068 6102 802A
     6902 804C 7202 804C 7A02 804C 6002 804C 0000
@0A0 0000 0000 0002 0001 0004 0001 0006 0000 0008 0001 000A 0005 000C FFFD
@0BD 0001 0000 0007
// block 3: j, jr, jal, jalr, then an undefined btr function
@0C0 C10C 2002 8020 2900 8020 8020 3002 8020 80E0 C220 3A02 8020 8020 8020
     8020 8020 8020 80E2 C911 8024
@0E0 0000 000E 0002 0016
@0FD 0001 0001 0002

// File: src.f
wiscIsaPkg.sv
wiscCtrlPkg.sv
controlUnit.sv
regFile.sv
alu.sv
pcUnit.sv
wiscCore.sv
wiscCore_assert.sv
wiscCore_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the wiscCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

logFile=sim.log
rm -f "$logFile"

verilator --binary --timing --assert -Wno-fatal \
   -f src.f --top-module wiscCore_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/VwiscCore_tb > "$logFile" 2>&1
runStatus=$?
cat "$logFile"

if [ $runStatus -ne 0 ]; then
   echo "simulation exited with status $runStatus"
   exit 1
fi

if grep -q "Something failed" "$logFile"; then
   exit 1
fi

exit 0
